// ==== verilog/fbuf_defs.svh ====
`ifndef FBUF_DEFS_SVH
`define FBUF_DEFS_SVH

// Bytes packed into one RAM word, one bank per byte lane
`define FBUF_WORD_BYTES 4

// RAM address width, the full buffer holds both halves
`define FBUF_ADDR_W 5

// Words in one half of the ping-pong buffer
`define FBUF_HALF_WORDS 16

// Longest frame a half can take
`define FBUF_MAX_BYTES 64

`endif

// ==== verilog/fbuf_pkg.sv ====
`include "fbuf_defs.svh"

package fbuf_pkg;

  // One RAM word, filled by lane in the packer and passed out whole by the drain
  typedef union packed {
    logic [`FBUF_WORD_BYTES*8-1:0]    word;
    logic [`FBUF_WORD_BYTES-1:0][7:0] bytes;
  } fbuf_word_u;

  typedef logic [`FBUF_ADDR_W-1:0] fbuf_addr_t;

  // Holds 1 to FBUF_MAX_BYTES inclusive
  typedef logic [$clog2(`FBUF_MAX_BYTES+1)-1:0] fbuf_len_t;

  typedef logic [`FBUF_WORD_BYTES-1:0] fbuf_mask_t;

endpackage

// ==== verilog/mem_2rw_sync.sv ====
module mem_2rw_sync
  #( parameter int width_p = 8
   , parameter int els_p   = 32
   )
  ( input  logic                     clk_i
  , input  logic                     rst_i

  , input  logic [width_p-1:0]       a_data_i
  , input  logic [$clog2(els_p)-1:0] a_addr_i
  , input  logic                     a_v_i
  , input  logic                     a_w_i

  , input  logic [width_p-1:0]       b_data_i
  , input  logic [$clog2(els_p)-1:0] b_addr_i
  , input  logic                     b_v_i
  , input  logic                     b_w_i

  , output logic [width_p-1:0]       a_data_o
  , output logic [width_p-1:0]       b_data_o
  );

  logic [width_p-1:0] mem [els_p];

  always_ff @(posedge clk_i)
  begin
    if (a_v_i && a_w_i)
    begin
      mem[a_addr_i] <= a_data_i;
    end
    if (b_v_i && b_w_i)
    begin
      mem[b_addr_i] <= b_data_i;
    end
  end

  // Read data appears the cycle after the request and holds until the next read
  always_ff @(posedge clk_i)
  begin
    if (a_v_i && !a_w_i)
    begin
      a_data_o <= mem[a_addr_i];
    end
    if (b_v_i && !b_w_i)
    begin
      b_data_o <= mem[b_addr_i];
    end
  end

  a_write_b_write: assert property (@(posedge clk_i) disable iff (rst_i)
    (a_v_i && a_w_i && b_v_i && b_w_i) |-> (a_addr_i != b_addr_i));

  a_write_b_read: assert property (@(posedge clk_i) disable iff (rst_i)
    (a_v_i && a_w_i && b_v_i && !b_w_i) |-> (a_addr_i != b_addr_i));

  b_write_a_read: assert property (@(posedge clk_i) disable iff (rst_i)
    (b_v_i && b_w_i && a_v_i && !a_w_i) |-> (a_addr_i != b_addr_i));

endmodule

// ==== verilog/mem_2rw_sync_mask_write_byte.sv ====
module mem_2rw_sync_mask_write_byte
  #( parameter int width_p = 32
   , parameter int els_p   = 32
   )
  ( input  logic                     clk_i
  , input  logic                     rst_i

  , input  logic [width_p-1:0]       a_data_i
  , input  logic [width_p/8-1:0]     a_w_mask_i
  , input  logic [$clog2(els_p)-1:0] a_addr_i
  , input  logic                     a_v_i
  , input  logic                     a_w_i

  , input  logic [width_p-1:0]       b_data_i
  , input  logic [width_p/8-1:0]     b_w_mask_i
  , input  logic [$clog2(els_p)-1:0] b_addr_i
  , input  logic                     b_v_i
  , input  logic                     b_w_i

  , output logic [width_p-1:0]       a_data_o
  , output logic [width_p-1:0]       b_data_o
  );

  if (width_p % 8 != 0)
  begin : g_width_check
    $error("mem_2rw_sync_mask_write_byte: width_p must be a multiple of 8");
  end

  for (genvar i = 0; i < width_p/8; i++)
  begin : g_lane
    logic a_en;
    logic b_en;

    // A masked-off write lane stays idle, so its bank and read register hold
    assign a_en = a_v_i && (!a_w_i || a_w_mask_i[i]);
    assign b_en = b_v_i && (!b_w_i || b_w_mask_i[i]);

    mem_2rw_sync
      #( .width_p (8)
       , .els_p   (els_p)
       )
      bank
      ( .clk_i    (clk_i)
      , .rst_i    (rst_i)
      , .a_data_i (a_data_i[i*8 +: 8])
      , .a_addr_i (a_addr_i)
      , .a_v_i    (a_en)
      , .a_w_i    (a_w_i)
      , .b_data_i (b_data_i[i*8 +: 8])
      , .b_addr_i (b_addr_i)
      , .b_v_i    (b_en)
      , .b_w_i    (b_w_i)
      , .a_data_o (a_data_o[i*8 +: 8])
      , .b_data_o (b_data_o[i*8 +: 8])
      );
  end

endmodule

// ==== verilog/byte_packer.sv ====
`include "fbuf_defs.svh"

module byte_packer
  ( input  logic                 clk_i
  , input  logic                 rst_i

  , input  logic                 in_v_i
  , input  logic [7:0]           in_byte_i
  , input  logic                 in_last_i

  , output logic                 ram_v_o
  , output fbuf_pkg::fbuf_addr_t ram_addr_o
  , output fbuf_pkg::fbuf_word_u ram_data_o
  , output fbuf_pkg::fbuf_mask_t ram_mask_o

  , output logic                 frame_v_o
  , output fbuf_pkg::fbuf_addr_t frame_base_o
  , output fbuf_pkg::fbuf_len_t  frame_len_o
  );

  localparam int lane_w_lp = $clog2(`FBUF_WORD_BYTES);

  logic [lane_w_lp-1:0]  lane;
  fbuf_pkg::fbuf_word_u  part;
  fbuf_pkg::fbuf_mask_t  mask_acc;
  fbuf_pkg::fbuf_addr_t  wr_addr;
  logic                  half;
  fbuf_pkg::fbuf_len_t   byte_cnt;

  logic                  done_q;
  fbuf_pkg::fbuf_addr_t  done_base;
  fbuf_pkg::fbuf_len_t   done_len;

  fbuf_pkg::fbuf_word_u  word_next;
  fbuf_pkg::fbuf_mask_t  mask_next;
  logic                  word_done;

  function automatic fbuf_pkg::fbuf_addr_t half_base(input logic h);
    half_base = h ? fbuf_pkg::fbuf_addr_t'(`FBUF_HALF_WORDS) : '0;
  endfunction

  always_comb
  begin
    word_next = part;
    word_next.bytes[lane] = in_byte_i;
    mask_next = mask_acc | fbuf_pkg::fbuf_mask_t'(1 << lane);
  end

  assign word_done = in_v_i && (in_last_i || (&lane));  // Top lane filled or frame ends

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      lane      <= '0;
      mask_acc  <= '0;
      wr_addr   <= '0;
      half      <= 1'b0;
      byte_cnt  <= '0;
      ram_v_o   <= 1'b0;
      done_q    <= 1'b0;
      frame_v_o <= 1'b0;
    end
    else
    begin
      ram_v_o   <= word_done;
      done_q    <= in_v_i && in_last_i;
      frame_v_o <= done_q;  // Announce one cycle after the final write
      if (done_q)
      begin
        frame_base_o <= done_base;
        frame_len_o  <= done_len;
      end
      if (word_done)
      begin
        ram_addr_o <= wr_addr;
        ram_data_o <= word_next;
        ram_mask_o <= mask_next;
      end
      if (in_v_i)
      begin
        byte_cnt <= byte_cnt + 1'b1;
        if (word_done)
        begin
          lane     <= '0;
          mask_acc <= '0;
          wr_addr  <= wr_addr + 1'b1;
        end
        else
        begin
          lane     <= lane + 1'b1;
          part     <= word_next;
          mask_acc <= mask_next;
        end
        if (in_last_i)
        begin
          done_base <= half_base(half);
          done_len  <= byte_cnt + 1'b1;
          half      <= ~half;  // The next frame fills the other half
          wr_addr   <= half_base(~half);
          byte_cnt  <= '0;
        end
      end
    end
  end

  // A frame must fit in one half of the buffer
  frame_fits_half: assert property (@(posedge clk_i) disable iff (rst_i)
    in_v_i |-> (byte_cnt < fbuf_pkg::fbuf_len_t'(`FBUF_MAX_BYTES)));

endmodule

// ==== verilog/frame_drain.sv ====
`include "fbuf_defs.svh"

module frame_drain
  ( input  logic                          clk_i
  , input  logic                          rst_i

  , input  logic                          frame_v_i
  , input  fbuf_pkg::fbuf_addr_t          frame_base_i
  , input  fbuf_pkg::fbuf_len_t           frame_len_i

  , output logic                          ram_v_o
  , output fbuf_pkg::fbuf_addr_t          ram_addr_o
  , input  fbuf_pkg::fbuf_word_u          ram_data_i

  , output logic                          out_v_o
  , output logic [`FBUF_WORD_BYTES*8-1:0] out_word_o
  , output fbuf_pkg::fbuf_mask_t          out_keep_o
  , output logic                          out_last_o
  );

  logic                  act_v;
  fbuf_pkg::fbuf_addr_t  act_addr;
  fbuf_pkg::fbuf_len_t   act_left;  // Words still to read, counting the current one
  fbuf_pkg::fbuf_mask_t  act_keep;

  logic                  pend_v;
  fbuf_pkg::fbuf_addr_t  pend_base;
  fbuf_pkg::fbuf_len_t   pend_left;
  fbuf_pkg::fbuf_mask_t  pend_keep;

  logic                  act_done;
  logic                  slot_free;

  function automatic fbuf_pkg::fbuf_len_t word_count(input fbuf_pkg::fbuf_len_t len);
    word_count = fbuf_pkg::fbuf_len_t'((len + `FBUF_WORD_BYTES - 1) / `FBUF_WORD_BYTES);
  endfunction

  function automatic fbuf_pkg::fbuf_mask_t last_keep(input fbuf_pkg::fbuf_len_t len);
    int rem;
    rem = len % `FBUF_WORD_BYTES;
    if (rem == 0)
      last_keep = '1;
    else
      last_keep = fbuf_pkg::fbuf_mask_t'((1 << rem) - 1);
  endfunction

  assign act_done  = act_v && (act_left == fbuf_pkg::fbuf_len_t'(1));
  assign slot_free = !act_v || act_done;

  assign ram_v_o    = act_v;
  assign ram_addr_o = act_addr;
  assign out_word_o = ram_data_i.word;  // RAM output is already registered

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      act_v      <= 1'b0;
      pend_v     <= 1'b0;
      out_v_o    <= 1'b0;
      out_last_o <= 1'b0;
    end
    else
    begin
      out_v_o    <= act_v;
      out_last_o <= act_done;
      out_keep_o <= act_done ? act_keep : '1;
      if (frame_v_i)
      begin
        pend_base <= frame_base_i;
        pend_left <= word_count(frame_len_i);
        pend_keep <= last_keep(frame_len_i);
      end
      if (slot_free && pend_v)
      begin
        // Queued frame follows straight on with no gap
        act_v    <= 1'b1;
        act_addr <= pend_base;
        act_left <= pend_left;
        act_keep <= pend_keep;
        pend_v   <= frame_v_i;
      end
      else if (slot_free && frame_v_i)
      begin
        act_v    <= 1'b1;
        act_addr <= frame_base_i;
        act_left <= word_count(frame_len_i);
        act_keep <= last_keep(frame_len_i);
      end
      else if (slot_free)
      begin
        act_v <= 1'b0;
      end
      else
      begin
        act_addr <= act_addr + 1'b1;
        act_left <= act_left - 1'b1;
        if (frame_v_i)
        begin
          pend_v <= 1'b1;
        end
      end
    end
  end

  // The packer must not announce a third frame while one is already queued
  no_pend_overrun: assert property (@(posedge clk_i) disable iff (rst_i)
    frame_v_i |-> !pend_v);

endmodule

// ==== verilog/frame_buffer_top.sv ====
`include "fbuf_defs.svh"

module frame_buffer_top
  ( input  logic                          clk_i
  , input  logic                          rst_i

  , input  logic                          in_v_i
  , input  logic [7:0]                    in_byte_i
  , input  logic                          in_last_i

  , output logic                          out_v_o
  , output logic [`FBUF_WORD_BYTES*8-1:0] out_word_o
  , output fbuf_pkg::fbuf_mask_t          out_keep_o
  , output logic                          out_last_o
  );

  logic                  ram_a_v;
  logic                  ram_a_w;
  fbuf_pkg::fbuf_addr_t  ram_a_addr;
  fbuf_pkg::fbuf_word_u  ram_a_data;
  fbuf_pkg::fbuf_mask_t  ram_a_mask;

  logic                  ram_b_v;
  logic                  ram_b_w;
  fbuf_pkg::fbuf_addr_t  ram_b_addr;
  fbuf_pkg::fbuf_word_u  ram_b_data;

  logic                  frame_v;
  fbuf_pkg::fbuf_addr_t  frame_base;
  fbuf_pkg::fbuf_len_t   frame_len;

  assign ram_a_w = 1'b1;  // Producer port only writes
  assign ram_b_w = 1'b0;  // Consumer port only reads

  byte_packer packer
    ( .clk_i        (clk_i)
    , .rst_i        (rst_i)
    , .in_v_i       (in_v_i)
    , .in_byte_i    (in_byte_i)
    , .in_last_i    (in_last_i)
    , .ram_v_o      (ram_a_v)
    , .ram_addr_o   (ram_a_addr)
    , .ram_data_o   (ram_a_data)
    , .ram_mask_o   (ram_a_mask)
    , .frame_v_o    (frame_v)
    , .frame_base_o (frame_base)
    , .frame_len_o  (frame_len)
    );

  mem_2rw_sync_mask_write_byte
    #( .width_p (`FBUF_WORD_BYTES*8)
     , .els_p   (1 << `FBUF_ADDR_W)
     )
    ram
    ( .clk_i      (clk_i)
    , .rst_i      (rst_i)
    , .a_data_i   (ram_a_data)
    , .a_w_mask_i (ram_a_mask)
    , .a_addr_i   (ram_a_addr)
    , .a_v_i      (ram_a_v)
    , .a_w_i      (ram_a_w)
    , .b_data_i   ('0)
    , .b_w_mask_i ('0)
    , .b_addr_i   (ram_b_addr)
    , .b_v_i      (ram_b_v)
    , .b_w_i      (ram_b_w)
    , .a_data_o   ()
    , .b_data_o   (ram_b_data)
    );

  frame_drain drain
    ( .clk_i        (clk_i)
    , .rst_i        (rst_i)
    , .frame_v_i    (frame_v)
    , .frame_base_i (frame_base)
    , .frame_len_i  (frame_len)
    , .ram_v_o      (ram_b_v)
    , .ram_addr_o   (ram_b_addr)
    , .ram_data_i   (ram_b_data)
    , .out_v_o      (out_v_o)
    , .out_word_o   (out_word_o)
    , .out_keep_o   (out_keep_o)
    , .out_last_o   (out_last_o)
    );

endmodule

// ==== dv/frame_buffer_tb.sv ====
`include "fbuf_defs.svh"

module frame_buffer_tb;

  localparam int wb_lp      = `FBUF_WORD_BYTES;
  localparam int bytes_lp   = 16 + 33 + 74 + 20*`FBUF_MAX_BYTES + 3 + 16;  // Most bytes any run sends
  localparam int timeout_lp = 5*200 + 2*bytes_lp;

  logic                 clk = 1'b0;
  logic                 rst;
  logic                 in_v;
  logic [7:0]           in_byte;
  logic                 in_last;
  logic                 out_v;
  logic [wb_lp*8-1:0]   out_word;
  logic [wb_lp-1:0]     out_keep;
  logic                 out_last;

  int                   cyc = 0;
  int                   checks = 0;
  int                   errors = 0;
  int                   half = 0;  // Half the next frame fills, tracks the packer
  int                   beats_exp = 0;
  int                   beats_seen = 0;
  logic [wb_lp*8-1:0]   mirror [1 << `FBUF_ADDR_W];
  logic [7:0]           frame_data [`FBUF_MAX_BYTES];
  logic [wb_lp*8+4:0]   exp_q [$];  // Beats packed as {last, keep, word}
  logic [wb_lp*8+4:0]   act_q [$];
  int                   act_cyc_q [$];
  logic [wb_lp*8-1:0]   seen_word [$];
  int                   seen_cyc [$];

  frame_buffer_top frame_buffer_top_inst
    ( .clk_i      (clk)
    , .rst_i      (rst)
    , .in_v_i     (in_v)
    , .in_byte_i  (in_byte)
    , .in_last_i  (in_last)
    , .out_v_o    (out_v)
    , .out_word_o (out_word)
    , .out_keep_o (out_keep)
    , .out_last_o (out_last)
    );

  always #10 clk = ~clk;

  always @(posedge clk)
    cyc <= cyc + 1;

  always @(negedge clk)
  begin
    if (out_v === 1'b1)
    begin
      act_q.push_back({out_last, out_keep, out_word});
      act_cyc_q.push_back(cyc);
      beats_seen++;
    end
  end

  initial
  begin
    repeat (timeout_lp) @(posedge clk);
    $display("Watchdog expired after %0d cycles while waiting for output", timeout_lp);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] act);
    checks++;
    if (exp !== act)
    begin
      errors++;
      $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic apply_reset();
    @(posedge clk);
    #2;
    rst = 1'b1;
    in_v = 1'b0;
    in_last = 1'b0;
    repeat (4) @(posedge clk);
    #2;
    rst = 1'b0;
    half = 0;
  endtask

  // Updates the mirror by the packer rules, queues the expected beats, then drives the bytes
  task automatic send_frame(input int len, input bit with_last, output int last_cyc);
    int               base;
    int               nwords;
    logic [wb_lp-1:0] keep;
    base = half * `FBUF_HALF_WORDS;
    nwords = (len + wb_lp - 1) / wb_lp;
    for (int i = 0; i < len; i++)
    begin
      frame_data[i] = 8'($urandom);
      if (with_last || i < len - len % wb_lp)  // A cut frame only leaves its whole words
        mirror[base + i / wb_lp][(i % wb_lp)*8 +: 8] = frame_data[i];
    end
    if (with_last)
    begin
      for (int w = 0; w < nwords; w++)
      begin
        for (int l = 0; l < wb_lp; l++)
          keep[l] = (w*wb_lp + l < len);
        exp_q.push_back({w == nwords - 1, keep, mirror[base + w]});
        beats_exp++;
      end
      half = 1 - half;
    end
    for (int i = 0; i < len; i++)
    begin
      @(posedge clk);
      #2;
      in_v = 1'b1;
      in_byte = frame_data[i];
      in_last = with_last && (i == len - 1);
    end
    last_cyc = cyc;
    @(posedge clk);
    #2;
    in_v = 1'b0;
    in_last = 1'b0;
  endtask

  task automatic compare_beats(input string name);
    logic [wb_lp*8+4:0] exp_beat;
    logic [wb_lp*8+4:0] act_beat;
    seen_word.delete();
    seen_cyc.delete();
    while (act_q.size() < exp_q.size())
      @(posedge clk);
    repeat (3) @(posedge clk);  // Room for a surplus beat to show up
    while (exp_q.size() > 0)
    begin
      exp_beat = exp_q.pop_front();
      act_beat = act_q.pop_front();
      compare(name, 64'(exp_beat), 64'(act_beat));
      seen_word.push_back(act_beat[wb_lp*8-1:0]);
      seen_cyc.push_back(act_cyc_q.pop_front());
    end
    if (act_q.size() != 0)
    begin
      errors++;
      $display("%s: %0d output beats arrived that belong to no frame", name, act_q.size());
      act_q.delete();
      act_cyc_q.delete();
    end
  endtask

  task automatic test_full_words();
    int last_cyc;
    send_frame(16, 1'b1, last_cyc);
    compare_beats("full_words");
    compare("full_words latency", 64'(4), 64'(seen_cyc[0] - last_cyc));
    for (int i = 1; i < 4; i++)
      compare("full_words spacing", 64'(1), 64'(seen_cyc[i] - seen_cyc[i-1]));
  endtask

  task automatic test_partial_word();
    int          last_cyc;
    logic [23:0] old_lanes;
    send_frame(16, 1'b1, last_cyc);
    old_lanes = {frame_data[15], frame_data[14], frame_data[13]};
    send_frame(4, 1'b1, last_cyc);
    send_frame(13, 1'b1, last_cyc);  // Lands in the same half as the 16-byte frame
    compare_beats("partial_word");
    compare("partial_word old lanes", 64'(old_lanes),
            64'(seen_word[seen_word.size()-1][31:8]));
  endtask

  task automatic test_ping_pong();
    int last_a;
    int last_b;
    send_frame(64, 1'b1, last_a);
    send_frame(10, 1'b1, last_b);  // Announced while the first frame still drains
    compare_beats("ping_pong");
    compare("ping_pong latency", 64'(4), 64'(seen_cyc[0] - last_a));
    for (int i = 1; i < 19; i++)
      compare("ping_pong gap", 64'(1), 64'(seen_cyc[i] - seen_cyc[i-1]));
  endtask

  task automatic test_random_frames();
    int need [20];
    int len;
    int last_cyc;
    for (int k = 0; k < 20; k++)
    begin
      // Frame k reuses the half of frame k-2, which must be fully out first
      if (k >= 2)
        while (beats_seen < need[k-2])
          @(posedge clk);
      repeat ($urandom % 4) @(posedge clk);
      len = (k < 2) ? `FBUF_MAX_BYTES : 1 + $urandom % `FBUF_MAX_BYTES;
      send_frame(len, 1'b1, last_cyc);
      need[k] = beats_exp;
    end
    compare_beats("random_frames");
  endtask

  task automatic test_reset_mid_frame();
    int last_cyc;
    if (half == 0)
    begin
      send_frame(3, 1'b1, last_cyc);  // Puts the cut frame in half 1
      compare_beats("reset_mid_frame filler");
    end
    send_frame(6, 1'b0, last_cyc);
    apply_reset();
    repeat (10) @(posedge clk);
    compare("reset_mid_frame no output", 64'(0), 64'(act_q.size()));
    send_frame(10, 1'b1, last_cyc);
    compare_beats("reset_mid_frame");
    compare("reset_mid_frame latency", 64'(4), 64'(seen_cyc[0] - last_cyc));
  endtask

  initial
  begin
    void'($urandom(32'hef50_2416));
    rst = 1'b1;
    in_v = 1'b0;
    in_byte = 8'h00;
    in_last = 1'b0;
    apply_reset();
    test_full_words();
    test_partial_word();
    test_ping_pong();
    test_random_frames();
    test_reset_mid_frame();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

// ==== flist.f ====
+incdir+verilog
verilog/fbuf_pkg.sv
verilog/mem_2rw_sync.sv
verilog/mem_2rw_sync_mask_write_byte.sv
verilog/byte_packer.sv
verilog/frame_drain.sv
verilog/frame_buffer_top.sv
dv/frame_buffer_tb.sv

// ==== Makefile ====
SIM     := verilator
FLAGS   := --binary --timing --assert -Wno-fatal
TOP     := frame_buffer_tb
FLIST   := flist.f
OBJ_DIR := obj_dir
LOG     := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST RESULT: PASS" $(LOG); then \
	  echo "Simulation passed"; \
	else \
	  echo "Simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
